// File: logic/am_consts.svh
// Alignment marker inserter constants.
// Block and field widths, lane count, default marker spacing and the
// fixed marker encoding of each lane.
`ifndef AM_CONSTS_SVH
`define AM_CONSTS_SVH

`define AM_LANES        4     // Lanes in one group.
`define AM_HEAD_W       2     // Sync header width.
`define AM_DATA_W       64    // Payload width.
`define AM_BLOCK_W      66    // Header plus payload.
`define AM_BIP_W        8     // Bit interleaved parity width.
`define AM_ENC_W        24    // Marker bytes M0 to M2.

`define AM_SPACING_DEF  16383 // Data groups between two markers.

// Lane encodings hold M0 in the low byte, so M0 lands in payload byte 0.
`define AM_LANE0_ENC    24'h477690
`define AM_LANE1_ENC    24'hE6C4F0
`define AM_LANE2_ENC    24'h9B65C5
`define AM_LANE3_ENC    24'h3D79A2

`endif

// File: logic/am_insert_fsm.sv
// Marker insertion FSM.
// Runs the upstream and downstream handshakes around the single output
// stage and decides for each output slot whether data or a marker is loaded.
// A marker is pending in MARK, or in PASS while the timer flags it due.
`timescale 1ns/1ns
`default_nettype none

module am_insert_fsm
	import am_pkg::*;
(
	input  wire logic clk,
	input  wire logic nreset,
	input  wire logic in_valid_i,
	output logic      in_ready_o,
	input  wire logic out_ready_i,
	output logic      out_valid_o,
	input  wire logic marker_due_i,
	output logic      load_o,
	output logic      marker_v_o,
	output logic      data_sent_o,
	output logic      marker_sent_o
);

	fsm_state_t state_q;
	fsm_state_t state_d;
	logic       out_valid_q;
	logic       slot_free;
	logic       mark_now;

	// The output register can take a group this cycle.
	assign slot_free = !out_valid_q || out_ready_i;

	// A marker goes into the next free slot.
	assign mark_now = (state_q == MARK) || marker_due_i;

	assign in_ready_o  = slot_free && !mark_now; // Upstream waits behind a marker.
	assign load_o      = slot_free && (mark_now || in_valid_i);
	assign marker_v_o  = mark_now;
	assign out_valid_o = out_valid_q;

	assign data_sent_o   = load_o && !mark_now;
	assign marker_sent_o = load_o && mark_now;

	always_comb begin
		state_d = state_q;
		case (state_q)
			MARK: begin
				if (slot_free) begin
					state_d = PASS; // The marker loads this cycle.
				end
			end
			PASS: begin
				// A due marker that cannot load now stays pending.
				if (marker_due_i && !slot_free) begin
					state_d = MARK;
				end
			end
			default: begin
				state_d = MARK;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state_q <= MARK; // The first group after reset is a marker.
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			out_valid_q <= 1'b0;
		end else if (load_o) begin
			out_valid_q <= 1'b1;
		end else if (out_ready_i) begin
			out_valid_q <= 1'b0; // Taken with nothing new behind it.
		end
	end

endmodule

`default_nettype wire

// File: logic/am_inserter_top.sv
// Four-lane alignment marker inserter.
// Passes groups of 66-bit blocks through one registered stage and puts
// a marker group in after every AM_SPACING data groups and after reset.
`timescale 1ns/1ns
`default_nettype none
`include "am_consts.svh"

module am_inserter_top
	import am_pkg::*;
#(
	parameter int AM_SPACING = `AM_SPACING_DEF
) (
	input  wire logic         clk,
	input  wire logic         nreset,
	input  wire logic         in_valid_i,
	output logic              in_ready_o,
	input  wire lane_blocks_t in_group_i,
	output logic              out_valid_o,
	input  wire logic         out_ready_i,
	output lane_blocks_t      out_group_o
);

	// Lane 0 in the low index.
	localparam logic [`AM_LANES-1:0][`AM_ENC_W-1:0] LANE_ENCS = {
		`AM_LANE3_ENC, `AM_LANE2_ENC, `AM_LANE1_ENC, `AM_LANE0_ENC
	};

	logic marker_due;
	logic load;
	logic marker_v;
	logic data_sent;
	logic marker_sent;

	am_spacing_timer #(
		.SPACING(AM_SPACING)
	) timer0 (
		.clk          (clk),
		.nreset       (nreset),
		.data_sent_i  (data_sent),
		.marker_sent_i(marker_sent),
		.marker_due_o (marker_due)
	);

	am_insert_fsm fsm0 (
		.clk          (clk),
		.nreset       (nreset),
		.in_valid_i   (in_valid_i),
		.in_ready_o   (in_ready_o),
		.out_ready_i  (out_ready_i),
		.out_valid_o  (out_valid_o),
		.marker_due_i (marker_due),
		.load_o       (load),
		.marker_v_o   (marker_v),
		.data_sent_o  (data_sent),
		.marker_sent_o(marker_sent)
	);

	for (genvar g = 0; g < `AM_LANES; g++) begin : g_lane
		am_lane_tx #(
			.LANE_ENC(LANE_ENCS[g])
		) lane (
			.clk       (clk),
			.nreset    (nreset),
			.load_i    (load),
			.marker_v_i(marker_v),
			.data_i    (in_group_i[g]),
			.data_o    (out_group_o[g])
		);
	end

endmodule

`default_nettype wire

// File: logic/am_lane_tx.sv
// Alignment marker lane transmitter.
// Builds the lane's marker block, keeps the running BIP3 of all blocks
// sent since the previous marker, and holds the lane's output register.
// The marker payload holds M0..M2, BIP3, ~M0..~M2 and ~BIP3 under a control header.
`timescale 1ns/1ns
`default_nettype none
`include "am_consts.svh"

module am_lane_tx
	import am_pkg::*;
#(
	parameter logic [`AM_ENC_W-1:0] LANE_ENC = `AM_LANE0_ENC
) (
	input  wire logic   clk,
	input  wire logic   nreset,
	input  wire logic   load_i,
	input  wire logic   marker_v_i,
	input  wire block_t data_i,
	output block_t      data_o
);

	bip_t   bip_q;
	block_t marker_blk;
	block_t data_q;

	// Payload bit j counts toward BIP bit j mod 8.
	// Header bits 0 and 1 fold into BIP bits 3 and 4.
	function automatic bip_t block_parity(input block_t blk);
		bip_t par;
		par = '0;
		for (int k = 0; k < `AM_DATA_W / `AM_BIP_W; k++) begin
			par ^= blk[`AM_HEAD_W + k * `AM_BIP_W +: `AM_BIP_W];
		end
		par[3] ^= blk[0];
		par[4] ^= blk[1];
		return par;
	endfunction

	// BIP3 carries the parity up to but not including this marker.
	assign marker_blk = {~bip_q, ~LANE_ENC, bip_q, LANE_ENC, SYNC_CTRL};

	always_ff @(posedge clk) begin
		if (!nreset) begin
			bip_q <= '0;
		end else if (load_i) begin
			if (marker_v_i) begin
				bip_q <= block_parity(marker_blk); // Next period includes this marker.
			end else begin
				bip_q <= bip_q ^ block_parity(data_i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			data_q <= marker_v_i ? marker_blk : data_i;
		end
	end

	assign data_o = data_q;

endmodule

`default_nettype wire

// File: logic/am_pkg.sv
// Alignment marker inserter types.
// Block, header and parity types, the lane group array, the
// state encoding of the insertion FSM and the sync header values.
`default_nettype none

package am_pkg;

	`include "am_consts.svh"

	// One 66-bit block. The sync header sits in bits 1:0.
	typedef logic [`AM_BLOCK_W-1:0] block_t;

	// The 2-bit sync header.
	typedef logic [`AM_HEAD_W-1:0] head_t;

	// The per-lane bit interleaved parity.
	typedef logic [`AM_BIP_W-1:0] bip_t;

	// One block per lane, lane 0 in the low index.
	typedef block_t [`AM_LANES-1:0] lane_blocks_t;

	// MARK means a marker is waiting for the output slot.
	typedef enum logic {
		MARK = 1'b0,
		PASS = 1'b1
	} fsm_state_t;

	localparam head_t SYNC_DATA = 2'b01; // Header of a data block.
	localparam head_t SYNC_CTRL = 2'b10; // Header of a control block.

endpackage

`default_nettype wire

// File: logic/am_spacing_timer.sv
// Marker spacing timer.
// Counts the data groups loaded since the last marker and flags
// when the next marker is due.
`timescale 1ns/1ns
`default_nettype none

module am_spacing_timer #(
	parameter int SPACING = 16383
) (
	input  wire logic clk,
	input  wire logic nreset,
	input  wire logic data_sent_i,
	input  wire logic marker_sent_i,
	output logic      marker_due_o
);

	localparam int CNT_W = $clog2(SPACING + 1);

	logic [CNT_W-1:0] cnt_q;
	logic             cnt_full;

	assign cnt_full = (cnt_q == CNT_W'(SPACING)); // Spacing reached.

	always_ff @(posedge clk) begin
		if (!nreset) begin
			cnt_q <= '0;
		end else if (marker_sent_i) begin
			cnt_q <= '0; // A new period starts with each marker.
		end else if (data_sent_i && !cnt_full) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// High in the cycle after the last data group of the period and held
	// until the marker has been loaded.
	assign marker_due_o = cnt_full;

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/am_pkg.sv
logic/am_spacing_timer.sv
logic/am_insert_fsm.sv
logic/am_lane_tx.sv
logic/am_inserter_top.sv
verif/am_clk_gen.sv
verif/am_tb.sv

// File: verif/am_clk_gen.sv
// Testbench clock and reset generator.
// Free running clock and an active low reset held for a number of cycles.
`timescale 1ns/1ns
`default_nettype none

module am_clk_gen #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_o,
	output logic nreset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o; // 10 ns period with the default.
	end

	initial begin
		nreset_o = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_o);
		nreset_o = 1'b1; // Released on a falling edge, away from the sampling edge.
	end

endmodule

`default_nettype wire

// File: verif/am_tb.sv
// Testbench for the four-lane alignment marker inserter.
// Drives groups with continuous and random handshakes, models the expected
// stream from the accepted groups and the marker rule, and checks every
// group taken at the output, including marker encodings and BIP3.
`timescale 1ns/1ns
`default_nettype none
`include "am_consts.svh"

module am_tb
	import am_pkg::*;
();

	localparam int SPACING     = 20;
	localparam int N_PASS      = 100;
	localparam int N_BP        = 300;
	localparam int N_TOTAL     = N_PASS + N_BP;
	localparam int EXP_MARKERS = 1 + N_TOTAL / SPACING;
	localparam int CYCLE_LIMIT = N_TOTAL * 4 + 200;

	logic         clk;
	logic         nreset;
	logic         in_valid_i;
	logic         in_ready_o;
	lane_blocks_t in_group_i;
	logic         out_valid_o;
	logic         out_ready_i;
	lane_blocks_t out_group_o;

	logic [31:0]  rng_state = 32'h613b5f2b;
	int           errs [1:5];
	int           cycle_cnt;
	int           rst_edges;
	bit           after_reset;
	bit           hold_pending;
	lane_blocks_t held_grp;
	lane_blocks_t acc_q [$]; // Accepted groups not yet seen at the output.
	int           idx_q [$];
	int           accepted;
	int           data_out;
	int           markers_seen;
	int           data_since_mark;
	bip_t         bip_run [`AM_LANES];
	bit           phase_rand;

	am_clk_gen clk_gen0 (
		.clk_o   (clk),
		.nreset_o(nreset)
	);

	am_inserter_top #(
		.AM_SPACING(SPACING)
	) dut0 (
		.clk        (clk),
		.nreset     (nreset),
		.in_valid_i (in_valid_i),
		.in_ready_o (in_ready_o),
		.in_group_i (in_group_i),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.out_group_o(out_group_o)
	);

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic lane_blocks_t make_group();
		lane_blocks_t grp;
		logic [31:0]  lo;
		logic [31:0]  hi;
		for (int l = 0; l < `AM_LANES; l++) begin
			lo = next_rand();
			hi = next_rand();
			grp[l] = {hi, lo, SYNC_DATA};
		end
		return grp;
	endfunction

	// Marker bytes M0 to M2 of each lane with M0 listed first.
	function automatic logic [7:0] enc_byte(input int lane, input int idx);
		logic [23:0] m;
		case (lane)
			0:       m = 24'h90_76_47;
			1:       m = 24'hF0_C4_E6;
			2:       m = 24'hC5_65_9B;
			default: m = 24'hA2_79_3D;
		endcase
		return m[23 - 8 * idx -: 8];
	endfunction

	// Block bit p (p >= 2) goes to BIP bit (p - 2) mod 8; the header feeds bits 3 and 4.
	function automatic bip_t block_parity(input block_t blk);
		bip_t bip;
		bip = '0;
		for (int p = 2; p < `AM_BLOCK_W; p++) begin
			bip[(p - 2) % 8] ^= blk[p];
		end
		bip[3] ^= blk[0];
		bip[4] ^= blk[1];
		return bip;
	endfunction

	// Expected marker block. Payload byte k sits at block bits 2+8k and up.
	function automatic block_t marker_block(input int lane, input bip_t bip);
		block_t blk;
		blk[1:0] = SYNC_CTRL;
		for (int b = 0; b < 3; b++) begin
			blk[2 + 8 * b +: 8]       = enc_byte(lane, b);
			blk[2 + 8 * (b + 4) +: 8] = ~enc_byte(lane, b);
		end
		blk[2 + 8 * 3 +: 8] = bip;
		blk[2 + 8 * 7 +: 8] = ~bip;
		return blk;
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1:       return "reset";
			2:       return "first marker";
			3:       return "pass-through and spacing";
			4:       return "BIP";
			default: return "back-pressure";
		endcase
	endfunction

	task automatic value_error(input int test_id, input string msg);
		errs[test_id]++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	task automatic plain_failure(input int test_id, input string msg);
		errs[test_id]++;
		$display("%s", msg);
	endtask

	task automatic report_test(input int id);
		$display("Test %0d %s: %s, %0d errors", id, test_name(id),
			(errs[id] == 0) ? "ok" : "failed", errs[id]);
	endtask

	// Compares one taken output group with the next group of the reference stream.
	task automatic check_output();
		block_t       exp;
		lane_blocks_t grp;
		int           idx;
		int           tid;
		if (markers_seen == 0 || data_since_mark == SPACING) begin
			tid = (markers_seen == 0) ? 2 : 4;
			for (int l = 0; l < `AM_LANES; l++) begin
				exp = marker_block(l, bip_run[l]);
				assert (out_group_o[l] === exp) else
					value_error(tid, $sformatf("lane %0d marker %0d is %h, expected %h",
						l, markers_seen, out_group_o[l], exp));
				if (markers_seen == 0) begin
					assert (out_group_o[l][1:0] === SYNC_CTRL && out_group_o[l][33:26] === 8'h00
						&& out_group_o[l][65:58] === 8'hFF) else
						value_error(2, $sformatf("lane %0d first marker has wrong header or BIP3", l));
				end
				bip_run[l] = block_parity(exp); // The next period counts this marker.
			end
			markers_seen++;
			data_since_mark = 0;
		end else if (acc_q.size() == 0) begin
			plain_failure(phase_rand ? 5 : 3,
				"A data group came out although no accepted group was waiting.");
		end else begin
			grp = acc_q.pop_front();
			idx = idx_q.pop_front();
			tid = (idx < N_PASS) ? 3 : 5;
			for (int l = 0; l < `AM_LANES; l++) begin
				assert (out_group_o[l] === grp[l] && out_group_o[l][1:0] === SYNC_DATA) else
					value_error(tid, $sformatf("lane %0d data group %0d is %h, expected %h",
						l, idx, out_group_o[l], grp[l]));
				bip_run[l] = bip_run[l] ^ block_parity(grp[l]);
			end
			data_out++;
			data_since_mark++;
		end
	endtask

	always @(posedge clk) begin
		if (!nreset) begin
			if (rst_edges > 0) begin
				assert (out_valid_o === 1'b0 && in_ready_o === 1'b0) else
					value_error(1, "out_valid_o or in_ready_o is not low during reset");
			end
			rst_edges++;
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				assert (out_valid_o === 1'b0 && in_ready_o === 1'b0) else
					value_error(1, "out_valid_o or in_ready_o is high in the first cycle after reset");
				after_reset = 1'b0;
			end
			if (hold_pending) begin
				assert (out_valid_o === 1'b1 && out_group_o === held_grp) else
					value_error(5, "output group or out_valid_o changed while stalled");
			end
			hold_pending = (out_valid_o === 1'b1) && !out_ready_i;
			held_grp = out_group_o;
			if (out_valid_o === 1'b1 && out_ready_i) begin
				check_output();
			end
			if (in_valid_i && in_ready_o === 1'b1) begin
				acc_q.push_back(in_group_i);
				idx_q.push_back(accepted);
				accepted++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without finishing the tests.", cycle_cnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Offers n_groups groups; a group stays on the bus until it is taken.
	task automatic drive_groups(input int n_groups, input bit rand_mode);
		int          sent;
		bit          pending;
		logic [31:0] r;
		sent = 0;
		pending = 1'b0;
		while (sent < n_groups) begin
			@(negedge clk);
			if (!pending) begin
				r = next_rand();
				if (!rand_mode || r[31:30] != 2'b00) begin
					in_group_i = make_group();
					in_valid_i = 1'b1;
					pending = 1'b1;
				end else begin
					in_valid_i = 1'b0;
				end
			end
			r = next_rand();
			out_ready_i = !rand_mode || (r[31:30] != 2'b00); // About 3 in 4 when random.
			@(posedge clk);
			if (in_valid_i && in_ready_o) begin
				pending = 1'b0;
				sent++;
			end
		end
		@(negedge clk);
		in_valid_i = 1'b0;
	endtask

	initial begin
		int total_err;
		int failed_tests;
		in_valid_i = 1'b0;
		out_ready_i = 1'b0;
		in_group_i = '0;
		phase_rand = 1'b0;
		for (int l = 0; l < `AM_LANES; l++) begin
			bip_run[l] = '0; // Parity counting starts from zero after reset.
		end
		@(posedge nreset);
		@(posedge clk);
		@(negedge clk);
		report_test(1);

		drive_groups(N_PASS, 1'b0);
		while (data_out < N_PASS) begin
			@(negedge clk);
		end
		report_test(2);
		report_test(3);

		phase_rand = 1'b1;
		drive_groups(N_BP, 1'b1);
		@(negedge clk);
		out_ready_i = 1'b1; // Drain the last groups and the closing marker.
		while (data_out < N_TOTAL || markers_seen < EXP_MARKERS) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		assert (out_valid_o === 1'b0) else
			plain_failure(5, "The output still offers a group after the last marker was taken.");
		report_test(4);
		report_test(5);

		total_err = 0;
		failed_tests = 0;
		for (int i = 1; i <= 5; i++) begin
			total_err += errs[i];
			if (errs[i] != 0) begin
				failed_tests++;
			end
		end
		$display("Tests run: 5, with errors: %0d, errors: %0d, data groups: %0d, markers: %0d",
			failed_tests, total_err, data_out, markers_seen);
		if (total_err == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
